/* source/dct_rot_pkg.sv */
/*
 * dct_rot_pkg
 * shared widths, supported frame sizes and bank geometry for the
 * DCT vector rotation reorder buffer, plus the frame size decode
 */
package dct_rot_pkg;

	// sample and stored word widths
	localparam int SAMPLE_W = 28;
	// real part sits above imag part
	localparam int WORD_W = 2 * SAMPLE_W;
	localparam int PTS_W = 12;

	// supported frame sizes
	localparam int MIN_PTS = 32;
	localparam int MAX_PTS = 256;

	// each bank holds one half of the largest frame
	localparam int BANK_DEPTH = MAX_PTS / 2;
	localparam int BANK_AW = $clog2(BANK_DEPTH);
	localparam int IDX_W = $clog2(MAX_PTS);

	// log2 of the frame size, unknown sizes fall back to the largest
	function automatic logic [3:0] pts_log2(input logic [PTS_W-1:0] pts);
		logic [3:0] lg;
		case (pts)
			PTS_W'(MIN_PTS):     lg = 4'($clog2(MIN_PTS));
			PTS_W'(MIN_PTS * 2): lg = 4'($clog2(MIN_PTS) + 1);
			PTS_W'(MIN_PTS * 4): lg = 4'($clog2(MIN_PTS) + 2);
			default:             lg = 4'($clog2(MAX_PTS));
		endcase
		return lg;
	endfunction

endpackage

/* source/dct_rot_if.sv */
/*
 * bank interfaces
 * bank_wr_if carries the shared write address and data with one
 * enable per bank; bank_rd_if carries both read addresses and the
 * words the banks return one cycle later
 */

// ----------------------------------------------------------------------
// write side, one writer feeding both banks
// ----------------------------------------------------------------------
interface bank_wr_if
	import dct_rot_pkg::*;
();
	// at most one enable high per cycle
	logic               wr_en_lo;
	logic               wr_en_hi;
	logic [BANK_AW-1:0] wr_addr;
	logic [WORD_W-1:0]  wr_data;

	modport writer (
		output wr_en_lo,
		output wr_en_hi,
		output wr_addr,
		output wr_data
	);

	modport bank (
		input wr_en_lo,
		input wr_en_hi,
		input wr_addr,
		input wr_data
	);
endinterface

// ----------------------------------------------------------------------
// read side, independent address per bank
// ----------------------------------------------------------------------
interface bank_rd_if
	import dct_rot_pkg::*;
();
	logic [BANK_AW-1:0] rd_addr_lo;
	logic [BANK_AW-1:0] rd_addr_hi;
	// registered bank outputs
	logic [WORD_W-1:0]  q_lo;
	logic [WORD_W-1:0]  q_hi;

	modport reader (
		output rd_addr_lo,
		output rd_addr_hi,
		input  q_lo,
		input  q_hi
	);
endinterface

/* source/frame_ctrl.sv */
/*
 * frame_ctrl
 * four state frame sequencer: idle, write, wait for the consumer,
 * read. owns in_ready and fires the readout trigger
 */
module frame_ctrl (
	input  logic clk,
	input  logic rst_n_sync,
	input  logic in_valid,
	input  logic in_sop,
	input  logic in_eop,
	input  logic out_ready,
	input  logic read_done,
	output logic in_ready,
	output logic accepting,
	output logic read_start
);
	localparam logic [1:0] ST_IDLE     = 2'd0;
	localparam logic [1:0] ST_WRITE    = 2'd1;
	localparam logic [1:0] ST_WAIT_OUT = 2'd2;
	localparam logic [1:0] ST_READ     = 2'd3;

	logic [1:0] state;
	logic [1:0] state_nxt;
	logic       take;

	// sample accepted this cycle
	assign take = in_valid & in_ready;

	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_IDLE:
				if (take && in_sop)
					state_nxt = ST_WRITE;
			ST_WRITE:
				if (take && in_eop)
					state_nxt = ST_WAIT_OUT;
			// hold the frame until the consumer is ready
			ST_WAIT_OUT:
				if (out_ready)
					state_nxt = ST_READ;
			ST_READ:
				if (read_done)
					state_nxt = ST_IDLE;
			default:
				state_nxt = ST_IDLE;
		endcase
	end

	// in_ready follows the state being entered
	always_ff @(posedge clk)
	begin
		if (!rst_n_sync)
		begin
			state    <= ST_IDLE;
			in_ready <= 1'b0;
		end
		else
		begin
			state    <= state_nxt;
			in_ready <= (state_nxt == ST_IDLE) || (state_nxt == ST_WRITE);
		end
	end

	assign accepting = in_ready;
	// single cycle pulse since state leaves WAIT_OUT on the next edge
	assign read_start = (state == ST_WAIT_OUT) && out_ready;

	// readout ends only in the read state with the input closed
	a_done_in_read: assert property (@(posedge clk) disable iff (!rst_n_sync)
		read_done |-> ((state == ST_READ) && !in_ready));

endmodule

/* source/write_decode.sv */
/*
 * write_decode
 * counts accepted samples, bit-reverses the count over log2(N) bits
 * to get the natural index and steers the sample into the low bank
 * (first half of the frame) or the high bank (second half)
 */
module write_decode
	import dct_rot_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n_sync,
	input  logic                in_valid,
	input  logic [SAMPLE_W-1:0] in_real,
	input  logic [SAMPLE_W-1:0] in_imag,
	input  logic                accepting,
	input  logic [PTS_W-1:0]    fftpts_in,
	bank_wr_if.writer           wr
);
	logic [IDX_W-1:0] cnt;
	logic [IDX_W-1:0] cnt_rev;
	logic [IDX_W-1:0] k;
	logic [IDX_W-1:0] half_n;
	logic [3:0]       log_n;
	logic             take;
	logic             in_lo;

	assign take = in_valid & accepting;

	// arrival counter cleared outside the input phase
	always_ff @(posedge clk)
	begin
		if (!rst_n_sync)
			cnt <= '0;
		else if (!accepting)
			cnt <= '0;
		else if (take)
			cnt <= cnt + 1'b1;
	end

	// ------------------------------------------------------------------
	// bit reversal over the active frame size
	// ------------------------------------------------------------------
	assign log_n  = pts_log2(fftpts_in);
	assign half_n = IDX_W'(1) << (log_n - 4'd1);

	// full width reverse before dropping the unused low bits
	always_comb
	begin
		for (int i = 0; i < IDX_W; i++)
			cnt_rev[i] = cnt[IDX_W-1-i];
	end

	assign k     = cnt_rev >> (4'(IDX_W) - log_n);
	assign in_lo = (k < half_n);

	// write in the same cycle as the accept
	assign wr.wr_en_lo = take && in_lo;
	assign wr.wr_en_hi = take && !in_lo;
	assign wr.wr_addr  = in_lo ? BANK_AW'(k) : BANK_AW'(k - half_n);
	assign wr.wr_data  = {in_real, in_imag};

	// accepted samples stay inside the selected frame size
	a_count_in_frame: assert property (@(posedge clk) disable iff (!rst_n_sync)
		take |-> ((cnt >> log_n) == '0));

endmodule

/* source/half_bank_ram.sv */
/*
 * half_bank_ram
 * one bank of sample storage, half the largest frame deep, with a
 * single write port and a registered read port
 */
module half_bank_ram
	import dct_rot_pkg::*;
(
	input  logic               clk,
	bank_wr_if.bank            wr,
	input  logic [BANK_AW-1:0] rd_addr,
	// picks which enable of the shared write bus is ours
	input  logic               wr_sel,
	output logic [WORD_W-1:0]  q
);
	logic [WORD_W-1:0] mem [BANK_DEPTH];
	logic              we;

	assign we = wr_sel ? wr.wr_en_hi : wr.wr_en_lo;

	// write, plus read with one cycle latency
	always_ff @(posedge clk)
	begin
		if (we)
			mem[wr.wr_addr] <= wr.wr_data;
		q <= mem[rd_addr];
	end

endmodule

/* source/pair_reader.sv */
/*
 * pair_reader
 * walks beat index j from 0 to N/2 and reads F(j) from the low bank
 * and F(N-j) from the high bank, then steers the two words into the
 * a/b output pair with sop/eop framing
 */
module pair_reader
	import dct_rot_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n_sync,
	input  logic                read_start,
	input  logic [PTS_W-1:0]    fftpts_in,
	bank_rd_if.reader           rd,
	output logic                read_done,
	output logic                out_valid,
	output logic                out_sop,
	output logic                out_eop,
	output logic [SAMPLE_W-1:0] out_a_real,
	output logic [SAMPLE_W-1:0] out_a_imag,
	output logic [SAMPLE_W-1:0] out_b_real,
	output logic [SAMPLE_W-1:0] out_b_imag
);
	// j needs one bit above the bank address to reach N/2
	logic [BANK_AW:0]  j;
	logic [BANK_AW:0]  j_d1;
	logic [BANK_AW:0]  half_n;
	logic [3:0]        log_n;
	logic              active;
	logic              valid_d1;
	logic [WORD_W-1:0] a_word;
	logic [WORD_W-1:0] b_word;

	assign log_n  = pts_log2(fftpts_in);
	assign half_n = {{BANK_AW{1'b0}}, 1'b1} << (log_n - 4'd1);

	// ------------------------------------------------------------------
	// one beat index per cycle after read_start
	// ------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n_sync)
		begin
			active <= 1'b0;
			j      <= '0;
		end
		else if (read_start)
		begin
			active <= 1'b1;
			j      <= '0;
		end
		else if (active)
		begin
			if (j == half_n)
				active <= 1'b0;
			else
				j <= j + 1'b1;
		end
	end

	assign read_done = active && (j == half_n);

	// low bank read at j and high bank at N/2-j
	assign rd.rd_addr_lo = j[BANK_AW-1:0];
	assign rd.rd_addr_hi = (j == '0) ? '0 : BANK_AW'(half_n - j);

	// stage 1 lines up with the registered bank output
	always_ff @(posedge clk)
	begin
		if (!rst_n_sync)
		begin
			valid_d1 <= 1'b0;
			j_d1     <= '0;
		end
		else
		begin
			valid_d1 <= active;
			j_d1     <= j;
		end
	end

	// ------------------------------------------------------------------
	// steering and output registers
	// ------------------------------------------------------------------
	// F(N/2) only lives in the high bank and F(0) only in the low bank
	assign a_word = (j_d1 == half_n) ? rd.q_hi : rd.q_lo;
	assign b_word = (j_d1 == '0) ? rd.q_lo : rd.q_hi;

	always_ff @(posedge clk)
	begin
		if (!rst_n_sync)
		begin
			out_valid <= 1'b0;
			out_sop   <= 1'b0;
			out_eop   <= 1'b0;
		end
		else
		begin
			out_valid <= valid_d1;
			out_sop   <= valid_d1 && (j_d1 == '0);
			out_eop   <= valid_d1 && (j_d1 == half_n);
		end
	end

	// payload loads on valid beats only
	always_ff @(posedge clk)
	begin
		if (valid_d1)
		begin
			out_a_real <= a_word[WORD_W-1:SAMPLE_W];
			out_a_imag <= a_word[SAMPLE_W-1:0];
			out_b_real <= b_word[WORD_W-1:SAMPLE_W];
			out_b_imag <= b_word[SAMPLE_W-1:0];
		end
	end

	a_j_in_range: assert property (@(posedge clk) disable iff (!rst_n_sync)
		active |-> (j <= half_n));

endmodule

/* source/dct_rot_top.sv */
/*
 * dct_rot_top
 * reorder buffer in front of the DCT vector rotation: takes one
 * bit-reversed frame, stores it in natural order over two banks and
 * emits N/2+1 beats of the pair F(j), F(N-j)
 */
module dct_rot_top
	import dct_rot_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n_sync,
	// input frame
	input  logic                in_valid,
	input  logic                in_sop,
	input  logic                in_eop,
	input  logic [SAMPLE_W-1:0] in_real,
	input  logic [SAMPLE_W-1:0] in_imag,
	input  logic [PTS_W-1:0]    fftpts_in,
	output logic                in_ready,
	// output pairs
	input  logic                out_ready,
	output logic                out_valid,
	output logic                out_sop,
	output logic                out_eop,
	output logic [SAMPLE_W-1:0] out_a_real,
	output logic [SAMPLE_W-1:0] out_a_imag,
	output logic [SAMPLE_W-1:0] out_b_real,
	output logic [SAMPLE_W-1:0] out_b_imag
);
	logic accepting;
	logic read_start;
	logic read_done;

	bank_wr_if wr_if ();
	bank_rd_if rd_if ();

	frame_ctrl u_frame_ctrl (
		.clk        (clk),
		.rst_n_sync (rst_n_sync),
		.in_valid   (in_valid),
		.in_sop     (in_sop),
		.in_eop     (in_eop),
		.out_ready  (out_ready),
		.read_done  (read_done),
		.in_ready   (in_ready),
		.accepting  (accepting),
		.read_start (read_start)
	);

	write_decode u_write_decode (
		.clk        (clk),
		.rst_n_sync (rst_n_sync),
		.in_valid   (in_valid),
		.in_real    (in_real),
		.in_imag    (in_imag),
		.accepting  (accepting),
		.fftpts_in  (fftpts_in),
		.wr         (wr_if.writer)
	);

	// ------------------------------------------------------------------
	// storage, low bank holds F(0..N/2-1), high bank F(N/2..N-1)
	// ------------------------------------------------------------------
	half_bank_ram u_bank_lo (
		.clk     (clk),
		.wr      (wr_if.bank),
		.rd_addr (rd_if.rd_addr_lo),
		.wr_sel  (1'b0),
		.q       (rd_if.q_lo)
	);

	half_bank_ram u_bank_hi (
		.clk     (clk),
		.wr      (wr_if.bank),
		.rd_addr (rd_if.rd_addr_hi),
		.wr_sel  (1'b1),
		.q       (rd_if.q_hi)
	);

	pair_reader u_pair_reader (
		.clk        (clk),
		.rst_n_sync (rst_n_sync),
		.read_start (read_start),
		.fftpts_in  (fftpts_in),
		.rd         (rd_if.reader),
		.read_done  (read_done),
		.out_valid  (out_valid),
		.out_sop    (out_sop),
		.out_eop    (out_eop),
		.out_a_real (out_a_real),
		.out_a_imag (out_a_imag),
		.out_b_real (out_b_real),
		.out_b_imag (out_b_imag)
	);

endmodule

/* tests/tb_dct_rot.sv */
/*
 * tb_dct_rot
 * random frame testbench for the DCT rotation reorder buffer:
 * sends bit-reversed frames of 32 to 256 points with random gaps and
 * consumer delays, checks every a/b pair and the output framing
 */
module tb_dct_rot
	import dct_rot_pkg::*;
();
	localparam int WAIT_LIMIT  = 4000;
	localparam int RESET_LIMIT = 4;
	localparam int NUM_FRAMES  = 12;

	logic                clk;
	logic                rst_n_sync;
	logic                in_valid;
	logic                in_sop;
	logic                in_eop;
	logic [SAMPLE_W-1:0] in_real;
	logic [SAMPLE_W-1:0] in_imag;
	logic [PTS_W-1:0]    fftpts_in;
	logic                out_ready;
	logic                in_ready;
	logic                out_valid;
	logic                out_sop;
	logic                out_eop;
	logic [SAMPLE_W-1:0] out_a_real;
	logic [SAMPLE_W-1:0] out_a_imag;
	logic [SAMPLE_W-1:0] out_b_real;
	logic [SAMPLE_W-1:0] out_b_imag;

	integer seed = 33706;
	int     value_errors;
	int     proto_errors;
	int     timeouts;
	bit     aborted;

	// model state, natural order frame and pending pairs
	logic [WORD_W-1:0] frame_mem [MAX_PTS];
	logic [WORD_W-1:0] exp_a_q [$];
	logic [WORD_W-1:0] exp_b_q [$];
	int                frame_beats;
	int                run_len;
	int                frames_done;

	dct_rot_top dut (
		.clk        (clk),
		.rst_n_sync (rst_n_sync),
		.in_valid   (in_valid),
		.in_sop     (in_sop),
		.in_eop     (in_eop),
		.in_real    (in_real),
		.in_imag    (in_imag),
		.fftpts_in  (fftpts_in),
		.in_ready   (in_ready),
		.out_ready  (out_ready),
		.out_valid  (out_valid),
		.out_sop    (out_sop),
		.out_eop    (out_eop),
		.out_a_real (out_a_real),
		.out_a_imag (out_a_imag),
		.out_b_real (out_b_real),
		.out_b_imag (out_b_imag)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// reverse the low bits of an arrival position
	function automatic int bit_reverse(input int value, input int bits);
		int r;
		r = 0;
		for (int i = 0; i < bits; i++)
			if (value[i])
				r = r | (1 << (bits - 1 - i));
		return r;
	endfunction

	task automatic compare_sample(input string name, input logic [SAMPLE_W-1:0] exp,
		input logic [SAMPLE_W-1:0] act);
		if (act !== exp)
		begin
			$display("CHECK FAILED %s expected %h got %h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic note_timeout(input string what);
		$display("timeout while waiting for %s", what);
		timeouts++;
		aborted = 1'b1;
	endtask

	// ------------------------------------------------------------------
	// output monitor, outputs are stable at the falling edge
	// ------------------------------------------------------------------
	always @(negedge clk)
	begin
		logic [WORD_W-1:0] exp_a;
		logic [WORD_W-1:0] exp_b;
		if (rst_n_sync && out_valid === 1'b1)
		begin
			if (exp_a_q.size() == 0)
			begin
				$display("out_valid high while no output beat was expected");
				proto_errors++;
			end
			else
			begin
				exp_a = exp_a_q.pop_front();
				exp_b = exp_b_q.pop_front();
				compare_sample("out_a_real", exp_a[WORD_W-1:SAMPLE_W], out_a_real);
				compare_sample("out_a_imag", exp_a[SAMPLE_W-1:0], out_a_imag);
				compare_sample("out_b_real", exp_b[WORD_W-1:SAMPLE_W], out_b_real);
				compare_sample("out_b_imag", exp_b[SAMPLE_W-1:0], out_b_imag);
				// sop on the first beat only, eop on the last only
				if (out_sop !== (run_len == 0))
				begin
					$display("CHECK FAILED out_sop expected %h got %h", run_len == 0, out_sop);
					value_errors++;
				end
				if (out_eop !== (run_len == frame_beats - 1))
				begin
					$display("CHECK FAILED out_eop expected %h got %h",
						run_len == frame_beats - 1, out_eop);
					value_errors++;
				end
				run_len++;
				if (run_len == frame_beats)
				begin
					run_len = 0;
					frames_done++;
				end
			end
		end
		else if (rst_n_sync && run_len != 0)
		begin
			$display("out_valid dropped after %0d of %0d beats", run_len, frame_beats);
			proto_errors++;
			run_len = 0;
		end
	end

	// one frame: model, bit-reversed input, back-pressure, readout
	task automatic run_frame(input logic [PTS_W-1:0] pts, input int n, input bit gaps);
		int                lg;
		int                idle;
		int                delay;
		int                lat;
		int                wait_cnt;
		int                target;
		logic [WORD_W-1:0] word;
		lg     = $clog2(n);
		target = frames_done + 1;
		for (int k = 0; k < n; k++)
			frame_mem[k] = {SAMPLE_W'($random(seed)), SAMPLE_W'($random(seed))};
		// beat j pairs F(j) with F((N-j) mod N)
		for (int j = 0; j <= n / 2; j++)
		begin
			exp_a_q.push_back(frame_mem[j]);
			exp_b_q.push_back(frame_mem[(n - j) % n]);
		end
		frame_beats = n / 2 + 1;

		@(posedge clk);
		fftpts_in <= pts;
		wait_cnt = 0;
		@(negedge clk);
		while (in_ready !== 1'b1)
		begin
			wait_cnt++;
			if (wait_cnt > WAIT_LIMIT)
			begin
				note_timeout("in_ready before a frame");
				return;
			end
			@(negedge clk);
		end

		// in_ready stays high until the eop beat is taken
		for (int c = 0; c < n; c++)
		begin
			idle = gaps ? ($unsigned($random(seed)) % 3) : 0;
			repeat (idle)
			begin
				@(posedge clk);
				in_valid <= 1'b0;
				in_sop   <= 1'b0;
				in_eop   <= 1'b0;
			end
			@(posedge clk);
			word = frame_mem[bit_reverse(c, lg)];
			in_valid <= 1'b1;
			in_sop   <= (c == 0);
			in_eop   <= (c == n - 1);
			in_real  <= word[WORD_W-1:SAMPLE_W];
			in_imag  <= word[SAMPLE_W-1:0];
		end
		@(posedge clk);
		in_valid <= 1'b0;
		in_sop   <= 1'b0;
		in_eop   <= 1'b0;

		// consumer not ready, buffer must hold and stay silent
		delay = $unsigned($random(seed)) % 20;
		repeat (delay)
		begin
			@(negedge clk);
			if (out_valid !== 1'b0)
			begin
				$display("out_valid high while out_ready was held low");
				proto_errors++;
			end
			if (in_ready !== 1'b0)
			begin
				$display("in_ready high while the frame waits for readout");
				proto_errors++;
			end
			@(posedge clk);
		end
		out_ready <= 1'b1;

		// fixed three cycle start latency
		lat = 0;
		@(negedge clk);
		while (out_valid !== 1'b1)
		begin
			lat++;
			if (lat > WAIT_LIMIT)
			begin
				note_timeout("out_valid after out_ready");
				return;
			end
			@(negedge clk);
		end
		if (lat != 3)
		begin
			$display("out_valid rose %0d cycles after out_ready, expected 3", lat);
			proto_errors++;
		end
		@(posedge clk);
		out_ready <= 1'b0;

		wait_cnt = 0;
		while (frames_done < target)
		begin
			wait_cnt++;
			if (wait_cnt > WAIT_LIMIT)
			begin
				note_timeout("the end of the output frame");
				return;
			end
			@(posedge clk);
		end
	endtask

	// ------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------
	initial
	begin
		int               wait_cnt;
		int               n;
		logic [PTS_W-1:0] pts;
		rst_n_sync = 1'b0;
		in_valid   = 1'b0;
		in_sop     = 1'b0;
		in_eop     = 1'b0;
		in_real    = '0;
		in_imag    = '0;
		fftpts_in  = PTS_W'(MIN_PTS);
		out_ready  = 1'b0;

		// quiet outputs and no in_ready during reset
		for (int i = 0; i < 10; i++)
		begin
			@(negedge clk);
			if (in_ready !== 1'b0 || out_valid !== 1'b0)
			begin
				$display("in_ready or out_valid high during reset");
				proto_errors++;
			end
		end
		@(posedge clk);
		rst_n_sync <= 1'b1;

		wait_cnt = 0;
		@(negedge clk);
		while (in_ready !== 1'b1 && !aborted)
		begin
			wait_cnt++;
			if (wait_cnt > RESET_LIMIT)
				note_timeout("in_ready after reset");
			else
				@(negedge clk);
		end
		if (out_valid !== 1'b0)
		begin
			$display("CHECK FAILED out_valid expected %h got %h", 1'b0, out_valid);
			value_errors++;
		end

		// each size once, then an unsupported size, then random sizes
		for (int f = 0; f < NUM_FRAMES; f++)
		begin
			if (aborted)
				break;
			if (f < 4)
				n = MIN_PTS << f;
			else if (f == 4)
				n = MAX_PTS;
			else
				n = MIN_PTS << ($unsigned($random(seed)) % 4);
			pts = (f == 4) ? PTS_W'(100) : PTS_W'(n);
			run_frame(pts, n, f != 0);
		end

		if (!aborted && exp_a_q.size() != 0)
		begin
			$display("%0d expected output beats never appeared", exp_a_q.size());
			proto_errors++;
		end

		$display("errors: value %0d, protocol %0d, timeout %0d",
			value_errors, proto_errors, timeouts);
		if (value_errors == 0 && proto_errors == 0 && timeouts == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* compile.f */
source/dct_rot_pkg.sv
source/dct_rot_if.sv
source/frame_ctrl.sv
source/write_decode.sv
source/half_bank_ram.sv
source/pair_reader.sv
source/dct_rot_top.sv
tests/tb_dct_rot.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the reorder buffer testbench with Verilator, run it, then
# decide pass or fail from the simulation log
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_dct_rot -f compile.f -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
	echo "simulation reported failure, see $LOG"
	exit 1
fi
echo "simulation clean, see $LOG"
